/* source/ptr_status_pkg.sv */
// Chunk pointer status definitions
package ptr_status_pkg;

    localparam int ptr_width = 26;                 // packet byte packing fixes this
    localparam int pkt_bytes = 5;                  // addr + 4 payload bytes
    localparam int num_chn   = 4;                  // compressor channels

    localparam logic [7:0] reg_mode_off = 8'h00;   // mode register
    localparam logic [7:0] reg_ctrl_off = 8'h04;   // chn n at +4n

    localparam logic [1:0] send_off    = 2'd0;     // no packets
    localparam logic [1:0] send_single = 2'd1;     // one packet, then off
    localparam logic [1:0] send_auto   = 2'd2;     // code 3 also auto

    // one APB write word, decoded by address
    typedef union packed {
        struct packed {
            logic        poll_en;                  // bit 31, never gated
            logic [14:0] rsvd;
            // per chn nibble {update_en, sel[1:0], spare}
            logic [3:0][3:0] chn;
        } mode;
        struct packed {
            logic [23:0] rsvd;
            logic [5:0]  seq;                      // packet sequence number
            logic [1:0]  send_mode;                // off / single / auto
        } ctrl;
    } apb_word_u;

endpackage

/* source/apb_status_regs.sv */
// APB status register block
`timescale 1ns/1ps

module apb_status_regs (
    input  logic        hclk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        poll_en,     // timer run
    output logic [7:0]  chn_sel,     // 2 bits per chn
    output logic [3:0]  ctrl_we,     // one-cycle strobe per chn
    output logic [1:0]  ctrl_mode,   // shared by all chn
    output logic [5:0]  ctrl_seq
);

    ptr_status_pkg::apb_word_u wd;   // write view
    ptr_status_pkg::apb_word_u rd;   // readback view
    logic [7:0]      ctrl_off;       // offset inside control window
    logic [1:0]      ctrl_chn;
    logic            is_mode;
    logic            is_ctrl;
    logic            mapped;
    logic            wr_en;
    logic [3:0][7:0] ctrl_rb;        // {seq, send_mode} per chn

    assign wd       = pwdata;
    assign ctrl_off = paddr - ptr_status_pkg::reg_ctrl_off;
    assign ctrl_chn = ctrl_off[3:2];
    assign is_mode  = (paddr == ptr_status_pkg::reg_mode_off);
    assign is_ctrl  = (ctrl_off[1:0] == 2'b00) && (ctrl_off[7:2] < ptr_status_pkg::num_chn);
    assign mapped   = is_mode || is_ctrl;
    assign wr_en    = psel && penable && pwrite && mapped;   // access phase only

    assign pready  = 1'b1;                                 // no wait states
    assign pslverr = psel && penable && !mapped;

    always_comb begin
        rd = '0;
        if (is_mode) begin
            rd.mode.poll_en = poll_en;
            for (int i = 0; i < ptr_status_pkg::num_chn; i++) begin
                rd.mode.chn[i] = {1'b1, chn_sel[2*i +: 2], 1'b0};  // current sel, enable set
            end
        end else if (is_ctrl) begin
            rd.ctrl.seq       = ctrl_rb[ctrl_chn][7:2];
            rd.ctrl.send_mode = ctrl_rb[ctrl_chn][1:0];         // as written
        end
    end
    assign prdata = rd;

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            poll_en   <= 1'b0;
            chn_sel   <= 8'h00;
            ctrl_we   <= 4'h0;
            ctrl_mode <= ptr_status_pkg::send_off;
            ctrl_seq  <= 6'h00;
            ctrl_rb   <= '0;
        end else begin
            ctrl_we <= 4'h0;                               // pulse
            if (wr_en && is_mode) begin
                poll_en <= wd.mode.poll_en;
                for (int i = 0; i < ptr_status_pkg::num_chn; i++) begin
                    if (wd.mode.chn[i][3]) chn_sel[2*i +: 2] <= wd.mode.chn[i][2:1];
                end
            end
            if (wr_en && is_ctrl) begin
                ctrl_we[ctrl_chn]  <= 1'b1;
                ctrl_mode          <= wd.ctrl.send_mode;
                ctrl_seq           <= wd.ctrl.seq;
                ctrl_rb[ctrl_chn]  <= {wd.ctrl.seq, wd.ctrl.send_mode};
            end
        end
    end

endmodule

/* source/ptr_poll_timer.sv */
// Pointer table poll timer
`timescale 1ns/1ps

module ptr_poll_timer #(
    parameter int POLL_CYCBITS = 3
) (
    input  logic       hclk,
    input  logic       rst_n,
    input  logic       poll_en,
    input  logic [7:0] chn_sel,
    output logic [3:0] chunk_ptr_ra,   // {sel ^ 1, chn}
    output logic       cap_stb,        // read data valid for cap_chn
    output logic [1:0] cap_chn
);

    localparam int CNT_W = POLL_CYCBITS + 2;

    logic [CNT_W-1:0] poll_cnt;        // {index, cntr}
    logic [1:0]       index;
    logic             stb_w;

    assign index = poll_cnt[CNT_W-1 -: 2];
    assign stb_w = poll_en && (poll_cnt[POLL_CYCBITS-1:0] == '0);   // chn boundary

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            poll_cnt     <= '0;
            chunk_ptr_ra <= 4'h0;
            cap_stb      <= 1'b0;
        end else begin
            if (!poll_en) poll_cnt <= '0;
            else          poll_cnt <= poll_cnt + CNT_W'(1);
            // low sel bit inverted so 0 selects end-of-frame
            if (stb_w) chunk_ptr_ra <= {chn_sel[{index, 1'b0} +: 2] ^ 2'b01, index};
            cap_stb <= stb_w;                               // table answers a cycle later
        end
    end

    assign cap_chn = chunk_ptr_ra[1:0];                    // stable until next boundary

endmodule

/* source/ptr_snapshot.sv */
// Pointer snapshot slots
`timescale 1ns/1ps

module ptr_snapshot (
    input  logic                                   hclk,
    input  logic                                   rst_n,
    input  logic                                   cap_stb,
    input  logic [1:0]                             cap_chn,
    input  logic [ptr_status_pkg::ptr_width-1:0]   chunk_ptr_rd,
    output logic [ptr_status_pkg::num_chn-1:0][ptr_status_pkg::ptr_width-1:0] slot_data,
    output logic [ptr_status_pkg::num_chn-1:0]     slot_changed
);

    logic [ptr_status_pkg::ptr_width-1:0] rot;     // rotated read data
    logic                                 differs;

    // rd[25:24] go to the bottom so byte 1 carries them next to seq
    assign rot     = {chunk_ptr_rd[23:0], chunk_ptr_rd[25:24]};
    assign differs = (rot != slot_data[cap_chn]);

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            slot_data    <= '0;                    // known compare base
            slot_changed <= '0;
        end else begin
            slot_changed <= '0;                    // pulse
            if (cap_stb) begin
                slot_data[cap_chn]    <= rot;
                slot_changed[cap_chn] <= differs;
            end
        end
    end

endmodule

/* source/status_packet_fsm.sv */
// Status packet serializer
`timescale 1ns/1ps

module status_packet_fsm #(
    parameter logic [7:0] ADDR_BYTE = 8'h20
) (
    input  logic                                 hclk,
    input  logic                                 rst_n,
    input  logic                                 ctrl_we,
    input  logic [1:0]                           ctrl_mode,
    input  logic [5:0]                           ctrl_seq,
    input  logic [ptr_status_pkg::ptr_width-1:0] slot,
    input  logic                                 slot_changed,
    input  logic                                 pkt_start,
    output logic [7:0]                           pkt_byte,
    output logic                                 pkt_rq
);

    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_rq   = 3'd1;     // address byte on offer
    localparam logic [2:0] st_b1   = 3'd2;
    localparam logic [2:0] st_b2   = 3'd3;
    localparam logic [2:0] st_b3   = 3'd4;
    localparam logic [2:0] st_b4   = 3'd5;

    logic [2:0]                           state;
    logic [1:0]                           mode_q;
    logic [1:0]                           mode_eff;
    logic [5:0]                           seq_q;
    logic [5:0]                           seq_eff;
    logic [5:0]                           seq_lat;    // seq of packet in flight
    logic [ptr_status_pkg::ptr_width-1:0] pay_q;      // payload of packet in flight
    logic                                 pend;       // request seen while busy
    logic                                 trig;
    logic                                 launch;

    // a write takes effect in the same cycle it arrives
    assign mode_eff = ctrl_we ? ctrl_mode : mode_q;
    assign seq_eff  = ctrl_we ? ctrl_seq : seq_q;
    assign trig     = (ctrl_we && (ctrl_mode == ptr_status_pkg::send_single)) ||
                      ((mode_eff >= ptr_status_pkg::send_auto) && slot_changed);
    assign launch   = (state == st_idle) &&
                      (trig || (pend && (mode_eff != ptr_status_pkg::send_off)));

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= st_idle;
            mode_q <= ptr_status_pkg::send_off;
            seq_q  <= 6'h00;
            pend   <= 1'b0;
        end else begin
            if (ctrl_we) begin
                mode_q <= ctrl_mode;
                seq_q  <= ctrl_seq;
            end
            if (launch && (mode_eff == ptr_status_pkg::send_single))
                mode_q <= ptr_status_pkg::send_off;          // single shot spent
            if (launch)                                      pend <= 1'b0;
            else if (ctrl_we && (ctrl_mode == ptr_status_pkg::send_off)) pend <= 1'b0;
            else if (trig)                                   pend <= 1'b1;  // busy, keep it
            case (state)
                st_idle: if (launch) state <= st_rq;
                st_rq:   if (pkt_start) state <= st_b1;
                st_b1:   state <= st_b2;
                st_b2:   state <= st_b3;
                st_b3:   state <= st_b4;
                default: state <= st_idle;                   // st_b4 and unused codes
            endcase
        end
    end

    always_ff @(posedge hclk) begin
        if (launch) begin
            pay_q   <= slot;                                 // frozen for the packet
            seq_lat <= seq_eff;
        end
    end

    assign pkt_rq = (state == st_rq);

    always_comb begin
        case (state)
            st_rq:   pkt_byte = ADDR_BYTE;
            st_b1:   pkt_byte = {seq_lat, pay_q[1:0]};
            st_b2:   pkt_byte = pay_q[9:2];
            st_b3:   pkt_byte = pay_q[17:10];
            st_b4:   pkt_byte = pay_q[25:18];
            default: pkt_byte = 8'h00;
        endcase
    end

endmodule

/* source/status_arbiter.sv */
// Round-robin status packet merge
`timescale 1ns/1ps

module status_arbiter (
    input  logic            hclk,
    input  logic            rst_n,
    input  logic [3:0][7:0] pkt_byte,
    input  logic [3:0]      pkt_rq,
    input  logic            status_start,
    output logic [3:0]      pkt_start,
    output logic [7:0]      status_ad,
    output logic            status_rq
);

    logic       active;       // a chn holds the output
    logic [1:0] grant;
    logic [1:0] last;         // last chn served
    logic [2:0] bcnt;         // payload bytes left, 0 in address phase
    logic [1:0] pick;
    logic       pick_vld;
    logic       addr_ph;

    // first requester after last, lowest distance wins
    always_comb begin
        pick     = last;
        pick_vld = 1'b0;
        for (int i = ptr_status_pkg::num_chn; i >= 1; i--) begin
            if (pkt_rq[2'(last + i)]) begin
                pick     = 2'(last + i);
                pick_vld = 1'b1;
            end
        end
    end

    always_ff @(posedge hclk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            grant  <= 2'd0;
            last   <= 2'd3;                               // chn 0 goes first
            bcnt   <= 3'd0;
        end else if (!active) begin
            if (pick_vld) begin
                active <= 1'b1;
                grant  <= pick;
            end
        end else if (bcnt == 3'd0) begin
            if (status_start && pkt_rq[grant]) begin
                bcnt <= 3'(ptr_status_pkg::pkt_bytes - 1);
                last <= grant;
            end
        end else begin
            bcnt <= bcnt - 3'd1;
            if (bcnt == 3'd1) active <= 1'b0;             // last payload byte out
        end
    end

    assign addr_ph   = active && (bcnt == 3'd0);
    assign status_rq = addr_ph && pkt_rq[grant];          // holds while start withheld
    assign status_ad = active ? pkt_byte[grant] : 8'h00;
    assign pkt_start = (status_start && status_rq) ? (4'b0001 << grant) : 4'b0000;

endmodule

/* source/ptr_status_top.sv */
// Chunk pointer status reporter top
`timescale 1ns/1ps

module ptr_status_top #(
    parameter int STATUS_BASE_ADDR = 'h20,    // chn n sends base + n
    parameter int POLL_CYCBITS     = 3
) (
    input  logic        hclk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [3:0]  chunk_ptr_ra,         // to external pointer table
    input  logic [ptr_status_pkg::ptr_width-1:0] chunk_ptr_rd,
    output logic [7:0]  status_ad,
    output logic        status_rq,
    input  logic        status_start
);

    logic        poll_en;
    logic [7:0]  chn_sel;
    logic [3:0]  ctrl_we;
    logic [1:0]  ctrl_mode;
    logic [5:0]  ctrl_seq;
    logic        cap_stb;
    logic [1:0]  cap_chn;
    logic [ptr_status_pkg::num_chn-1:0][ptr_status_pkg::ptr_width-1:0] slot_data;
    logic [ptr_status_pkg::num_chn-1:0] slot_changed;
    logic [3:0][7:0] pkt_byte;
    logic [3:0]      pkt_rq;
    logic [3:0]      pkt_start;

    apb_status_regs apb_status_regs_i (
        .hclk      (hclk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .poll_en   (poll_en),
        .chn_sel   (chn_sel),
        .ctrl_we   (ctrl_we),
        .ctrl_mode (ctrl_mode),
        .ctrl_seq  (ctrl_seq)
    );

    ptr_poll_timer #(
        .POLL_CYCBITS (POLL_CYCBITS)
    ) ptr_poll_timer_i (
        .hclk         (hclk),
        .rst_n        (rst_n),
        .poll_en      (poll_en),
        .chn_sel      (chn_sel),
        .chunk_ptr_ra (chunk_ptr_ra),
        .cap_stb      (cap_stb),
        .cap_chn      (cap_chn)
    );

    ptr_snapshot ptr_snapshot_i (
        .hclk         (hclk),
        .rst_n        (rst_n),
        .cap_stb      (cap_stb),
        .cap_chn      (cap_chn),
        .chunk_ptr_rd (chunk_ptr_rd),
        .slot_data    (slot_data),
        .slot_changed (slot_changed)
    );

    for (genvar i = 0; i < ptr_status_pkg::num_chn; i++) begin : g_chn
        status_packet_fsm #(
            .ADDR_BYTE (8'(STATUS_BASE_ADDR + i))
        ) status_packet_fsm_i (
            .hclk         (hclk),
            .rst_n        (rst_n),
            .ctrl_we      (ctrl_we[i]),
            .ctrl_mode    (ctrl_mode),
            .ctrl_seq     (ctrl_seq),
            .slot         (slot_data[i]),
            .slot_changed (slot_changed[i]),
            .pkt_start    (pkt_start[i]),
            .pkt_byte     (pkt_byte[i]),
            .pkt_rq       (pkt_rq[i])
        );
    end

    status_arbiter status_arbiter_i (
        .hclk         (hclk),
        .rst_n        (rst_n),
        .pkt_byte     (pkt_byte),
        .pkt_rq       (pkt_rq),
        .status_start (status_start),
        .pkt_start    (pkt_start),
        .status_ad    (status_ad),
        .status_rq    (status_rq)
    );

endmodule

/* test/ptr_status_checks.sv */
// Status packet checker
`timescale 1ns/1ps

module ptr_status_checks #(
    parameter int BASE_ADDR    = 'h20,
    parameter int POLL_CYCBITS = 3
) (
    input  logic             hclk,
    input  logic             rst_n,
    input  string            tname,        // current test
    input  logic [7:0]       status_ad,
    input  logic             status_rq,
    input  logic             status_start,
    input  logic [3:0]       chunk_ptr_ra,
    input  logic             poll_chk,     // selects settled, check addressing
    input  logic [21:0]      pattern,      // table model low bits
    input  logic [7:0]       exp_sel,
    input  logic [3:0][5:0]  exp_seq,
    output logic [3:0][15:0] pkt_cnt,      // packets seen per chn
    output int               err_cnt
);

    int         sb_err = 0;   // scoreboard and poll errors
    int         sva_err = 0;  // handshake errors
    int         bidx;         // next payload byte, 0 between packets
    int         gap;          // cycles since last ra change
    logic [1:0] chn;
    logic [3:0] ra_prev;
    logic       ra_seen;
    logic [7:0] exp;

    // table answers {ra, pattern}, ra = {sel ^ 1, chn}; rd[25:24] end up at the bottom
    function automatic logic [7:0] exp_byte(input logic [1:0] ch, input int idx);
        case (idx)
            1:       exp_byte = {exp_seq[ch], exp_sel[2*ch +: 2] ^ 2'b01};
            2:       exp_byte = pattern[7:0];
            3:       exp_byte = pattern[15:8];
            default: exp_byte = {ch, pattern[21:16]};
        endcase
    endfunction

    always @(negedge hclk) begin
        if (!rst_n) begin
            bidx    = 0;
            gap     = 0;
            ra_seen = 1'b0;
            ra_prev = chunk_ptr_ra;
            pkt_cnt = '0;
        end else begin
            gap = gap + 1;
            if (chunk_ptr_ra != ra_prev) begin               // new poll slot
                if (poll_chk && ra_seen) begin
                    assert (chunk_ptr_ra[1:0] == ra_prev[1:0] + 2'd1 && gap == 2 ** POLL_CYCBITS)
                    else begin
                        sb_err++;
                        $display("mismatch %s ra step exp chn %0d after %0d act chn %0d after %0d",
                                 tname, ra_prev[1:0] + 2'd1, 2 ** POLL_CYCBITS,
                                 chunk_ptr_ra[1:0], gap);
                    end
                end
                if (poll_chk) begin
                    assert (chunk_ptr_ra[3:2] == (exp_sel[2*chunk_ptr_ra[1:0] +: 2] ^ 2'b01))
                    else begin
                        sb_err++;
                        $display("mismatch %s ra sel exp %0d act %0d", tname,
                                 exp_sel[2*chunk_ptr_ra[1:0] +: 2] ^ 2'b01, chunk_ptr_ra[3:2]);
                    end
                end
                ra_seen = poll_chk;
                ra_prev = chunk_ptr_ra;
                gap     = 0;
            end
            if (bidx != 0) begin                             // payload, one byte per cycle
                exp = exp_byte(chn, bidx);
                assert (status_ad == exp && !status_rq) else begin
                    sb_err++;
                    $display("mismatch %s chn %0d byte %0d exp %02h act %02h rq %b",
                             tname, chn, bidx, exp, status_ad, status_rq);
                end
                bidx = (bidx == 4) ? 0 : bidx + 1;
            end else if (status_rq && status_start) begin   // address byte accepted
                assert (status_ad >= 8'(BASE_ADDR) && status_ad < 8'(BASE_ADDR + 4)) else begin
                    sb_err++;
                    $display("mismatch %s address byte exp %02h to %02h act %02h", tname,
                             8'(BASE_ADDR), 8'(BASE_ADDR + 3), status_ad);
                end
                chn          = 2'(status_ad - 8'(BASE_ADDR));
                pkt_cnt[chn] = pkt_cnt[chn] + 16'd1;
                bidx         = 1;
            end
        end
    end

    // start withheld, so request and address byte stay put
    hold_rq: assert property (@(posedge hclk) disable iff (!rst_n)
        status_rq && !status_start |=> status_rq && $stable(status_ad))
        else begin
            sva_err++;
            $display("%s: request or address byte changed while status_start was withheld",
                     tname);
        end

    assign err_cnt = sb_err + sva_err;

endmodule

/* test/ptr_status_tb.sv */
// Chunk pointer status testbench
`timescale 1ns/1ps

module ptr_status_tb;

    localparam int base_addr = 'h20;
    localparam int poll_bits = 3;
    localparam int round_cyc = 4 * (2 ** poll_bits);   // one sweep over all chn
    // reset and apb, poll, single, auto, arbitration budgets
    localparam int test_cyc  = 40 + 3 * round_cyc + 4 * 48 + 4 * round_cyc + 120;

    logic             hclk;
    logic             rst_n;
    logic             psel, penable, pwrite;
    logic [7:0]       paddr;
    logic [31:0]      pwdata, prdata;
    logic             pready, pslverr;
    logic [3:0]       chunk_ptr_ra;
    logic [25:0]      chunk_ptr_rd;
    logic [7:0]       status_ad;
    logic             status_rq;
    logic             status_start = 1'b0;
    logic [21:0]      pattern;        // low table bits
    logic [7:0]       exp_sel;
    logic [3:0][5:0]  exp_seq;
    logic [3:0][15:0] pkt_cnt, cnt_base;
    logic             poll_chk;
    logic             hold_start;     // responder holds off start
    logic [31:0]      rdata;
    logic             rerr;
    int               seed = 34;
    int               tb_err = 0;
    int               chk_err;
    string            tname = "reset";

    ptr_status_top #(
        .STATUS_BASE_ADDR (base_addr),
        .POLL_CYCBITS     (poll_bits)
    ) ptr_status_top_i (.*);

    ptr_status_checks #(
        .BASE_ADDR    (base_addr),
        .POLL_CYCBITS (poll_bits)
    ) checks_i (.*, .err_cnt(chk_err));

    always #2 hclk = ~hclk;                             // 4 ns

    assign chunk_ptr_rd = {chunk_ptr_ra, pattern};      // pointer table model

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data);
        @(posedge hclk);
        #1;
        {psel, penable, pwrite, paddr, pwdata} = {2'b10, wr, addr, data};   // setup
        @(posedge hclk);
        #1;
        penable = 1'b1;
        @(negedge hclk);                                // access phase sample
        rdata = prdata;
        rerr  = pslverr;
        expect_eq("pready", 32'd1, 32'(pready));
        @(posedge hclk);
        #1;
        {psel, penable} = 2'b00;
    endtask

    task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            tb_err++;
            $display("mismatch %s %s exp %0h act %0h", tname, what, exp, act);
        end
    endtask

    // {poll_en, nibble per chn of {update_en, sel, spare}}
    function automatic logic [31:0] mode_word(input logic pe, input logic [3:0] upd,
                                              input logic [7:0] sel);
        logic [31:0] w;
        w = {pe, 31'h0};
        for (int i = 0; i < 4; i++) begin
            w[4*i +: 4] = {upd[i], sel[2*i +: 2], 1'b0};
        end
        return w;
    endfunction

    task automatic ctrl_write(input int ch, input logic [1:0] mode, input logic [5:0] seq);
        exp_seq[ch] = seq;
        apb_xfer(1'b1, 8'(4 + 4 * ch), {24'h0, seq, mode});
    endtask

    // one more packet than cnt_base on every chn in mask
    task automatic wait_pkts(input logic [3:0] mask, input int max_cyc);
        logic done;
        done = 1'b0;
        for (int n = 0; n < max_cyc && !done; n++) begin
            @(posedge hclk);
            done = 1'b1;
            for (int c = 0; c < 4; c++) begin
                if (mask[c] && pkt_cnt[c] == cnt_base[c]) done = 1'b0;
            end
        end
        if (!done) begin
            tb_err++;
            $display("%s: no packet within %0d cycles on chn mask %b", tname, max_cyc, mask);
        end
    endtask

    task automatic expect_counts(input logic [3:0] mask);
        for (int c = 0; c < 4; c++) begin
            expect_eq($sformatf("chn %0d packets", c),
                      32'(cnt_base[c]) + 32'(mask[c]), 32'(pkt_cnt[c]));
        end
        cnt_base = pkt_cnt;
    endtask

    initial begin : responder
        int d;
        forever begin
            @(negedge hclk);
            if (status_rq && !hold_start) begin
                d = $random(seed) & 7;                  // 0 to 7 cycles of back-pressure
                repeat (d) @(negedge hclk);
                @(posedge hclk);
                #1;
                status_start = 1'b1;
                @(posedge hclk);
                #1;
                status_start = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(2 * test_cyc * 4);
        $display("watchdog: run did not finish within %0d cycles", 2 * test_cyc);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        hclk = 1'b0;
        rst_n = 1'b0;
        {psel, penable, pwrite, paddr, pwdata} = '0;
        {poll_chk, hold_start} = 2'b00;
        pattern = 22'h2a5c31;
        exp_sel = 8'h00;
        exp_seq = '0;
        repeat (10) @(posedge hclk);
        #1;
        rst_n = 1'b1;
        @(negedge hclk);
        expect_eq("status_rq", 32'd0, 32'(status_rq));
        expect_eq("pslverr", 32'd0, 32'(pslverr));
        expect_eq("chunk_ptr_ra", 32'd0, 32'(chunk_ptr_ra));

        tname = "apb";
        apb_xfer(1'b1, 8'h40, 32'h1);                   // unmapped
        expect_eq("pslverr", 32'd1, 32'(rerr));
        apb_xfer(1'b1, 8'h00, mode_word(1'b1, 4'hf, 8'b00_11_01_10));
        apb_xfer(1'b0, 8'h00, 32'h0);
        expect_eq("mode readback", mode_word(1'b1, 4'hf, 8'b00_11_01_10), rdata);
        apb_xfer(1'b1, 8'h00, mode_word(1'b1, 4'b1101, 8'b01_11_10_10));   // chn 1 kept
        exp_sel = 8'b01_11_01_10;
        apb_xfer(1'b0, 8'h00, 32'h0);
        expect_eq("mode readback", mode_word(1'b1, 4'hf, exp_sel), rdata);

        tname = "poll";
        repeat (4) @(posedge hclk);
        poll_chk = 1'b1;                                // stays on from here
        repeat (3 * round_cyc) @(posedge hclk);

        tname = "single";
        cnt_base = pkt_cnt;
        for (int c = 0; c < 4; c++) begin
            ctrl_write(c, 2'd1, 6'(5 * c + 3));
            wait_pkts(4'b0001 << c, 40);
            repeat (8) @(posedge hclk);
            expect_counts(4'b0001 << c);
        end

        tname = "auto";
        ctrl_write(2, 2'd2, 6'h2a);
        ctrl_write(3, 2'd2, 6'h15);
        ctrl_write(3, 2'd0, 6'h15);                     // auto cancelled again
        pattern = 22'($random(seed));                   // every slot changes
        wait_pkts(4'b0100, 2 * round_cyc);
        repeat (2 * round_cyc) @(posedge hclk);
        expect_counts(4'b0100);

        tname = "arbitration";
        hold_start = 1'b1;
        for (int c = 0; c < 4; c++) begin
            ctrl_write(c, 2'd1, 6'(c + 40));
        end
        repeat (10) @(posedge hclk);
        hold_start = 1'b0;
        wait_pkts(4'hf, 100);
        repeat (10) @(posedge hclk);
        expect_counts(4'hf);

        $display("errors: testbench %0d, checker %0d", tb_err, chk_err);
        if (tb_err + chk_err == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* project.f */
source/ptr_status_pkg.sv
source/apb_status_regs.sv
source/ptr_poll_timer.sv
source/ptr_snapshot.sv
source/status_packet_fsm.sv
source/status_arbiter.sv
source/ptr_status_top.sv
test/ptr_status_checks.sv
test/ptr_status_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert -Wno-fatal -f project.f --top-module ptr_status_tb \
    -o ptr_status_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/ptr_status_sim > "$log" 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited abnormally, see $log"
    exit 1
fi

if grep -q "ERRORS FOUND" "$log"; then
    echo "FAIL, see $log"
    exit 1
fi
echo "PASS"
exit 0
